// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - soc_map_pkg.sv
  - bus_pkg.sv
  - addr_decoder.sv
  - bus_sequencer.sv
  - ram_port.sv
  - plic_target.sv
  - plic.sv
  - mtimer.sv
  - soc_bus_top.sv
  - target: simulation
    files:
      - tb_soc_bus.sv

// ==== addr_decoder.sv ====
`timescale 1ns/100ps

module addr_decoder
    import soc_map_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic [ADDR_W-1:0] addr,
    output region_e           region,
    output logic [ADDR_W-1:0] offset
);
    // ram window size in bytes
    localparam logic [ADDR_W-1:0] RAM_SIZE = ADDR_W'(RAM_WORDS * 4);

    always_comb begin
        region = region_none;
        offset = '0;
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE) begin
            region = region_ram;
            offset = addr - RAM_BASE;
        end else if (addr >= PLIC_BASE && addr < PLIC_BASE + PLIC_SIZE) begin
            region = region_plic;
            offset = addr - PLIC_BASE;
        end else if (addr >= TIMER_BASE && addr < TIMER_BASE + TIMER_SIZE) begin
            region = region_timer;
            offset = addr - TIMER_BASE;
        end
    end

endmodule

// ==== bus_pkg.sv ====
package bus_pkg;
    import soc_map_pkg::*;

    localparam int DATA_W = 64;

    // load/store width, funct3 encoding
    // stores look at the low two bits only
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_e;

    // master request, sampled with req_valid
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        ls_type_e          ls_type;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // per-target command, strobes one cycle wide
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] offset;
        ls_type_e          ls_type;
        logic [DATA_W-1:0] wdata;
    } tgt_cmd_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } tgt_rsp_t;

endpackage

// ==== bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer
    import soc_map_pkg::*;
    import bus_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              req_valid,
    input  bus_req_t          req,
    input  region_e           region,
    input  logic [ADDR_W-1:0] offset,
    output tgt_cmd_t          ram_cmd,
    output tgt_cmd_t          plic_cmd,
    output tgt_cmd_t          timer_cmd,
    input  tgt_rsp_t          ram_rsp,
    input  tgt_rsp_t          plic_rsp,
    input  tgt_rsp_t          timer_rsp,
    output logic [ADDR_W-1:0] cur_addr,
    output logic              done,
    output logic [DATA_W-1:0] rdata
);
    bus_req_t          req_q;
    region_e           sel_q;
    logic              issue;
    logic              rd_q;
    logic              wr_q;
    logic              busy;
    tgt_cmd_t          base_cmd;
    logic              tgt_ack;
    logic [DATA_W-1:0] tgt_data;

    // captured request, held until the next one
    always_ff @(posedge CLOCK_50) begin
        if (req_valid && done) begin
            req_q <= req;
        end
    end

    assign cur_addr = req_q.addr;

    // edge 0 takes the request, edge 1 fires the strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            done  <= 1'b1;
            issue <= 1'b0;
            rd_q  <= 1'b0;
            wr_q  <= 1'b0;
            busy  <= 1'b0;
            sel_q <= region_none;
            rdata <= '0;
        end else begin
            issue <= req_valid && done;
            rd_q  <= issue && !req_q.write;
            wr_q  <= issue && req_q.write;
            if (req_valid && done) begin
                done <= 1'b0;
            end
            // region is settled by now, lock the target in
            if (issue) begin
                sel_q <= region;
                busy  <= 1'b1;
            end
            if (busy && tgt_ack) begin
                busy <= 1'b0;
                done <= 1'b1;
                if (!req_q.write) begin
                    rdata <= tgt_data;
                end
            end
        end
    end

    // same payload to every target, strobes only to the selected one
    always_comb begin
        base_cmd.rd      = 1'b0;
        base_cmd.wr      = 1'b0;
        base_cmd.offset  = offset;
        base_cmd.ls_type = req_q.ls_type;
        base_cmd.wdata   = req_q.wdata;
        ram_cmd          = base_cmd;
        plic_cmd         = base_cmd;
        timer_cmd        = base_cmd;
        ram_cmd.rd       = rd_q && sel_q == region_ram;
        ram_cmd.wr       = wr_q && sel_q == region_ram;
        plic_cmd.rd      = rd_q && sel_q == region_plic;
        plic_cmd.wr      = wr_q && sel_q == region_plic;
        timer_cmd.rd     = rd_q && sel_q == region_timer;
        timer_cmd.wr     = wr_q && sel_q == region_timer;
    end

    // response select
    // unmapped completes by itself with zero data
    always_comb begin
        case (sel_q)
            region_ram: begin
                tgt_ack  = ram_rsp.ack;
                tgt_data = ram_rsp.rdata;
            end
            region_plic: begin
                tgt_ack  = plic_rsp.ack;
                tgt_data = plic_rsp.rdata;
            end
            region_timer: begin
                tgt_ack  = timer_rsp.ack;
                tgt_data = timer_rsp.rdata;
            end
            default: begin
                tgt_ack  = 1'b1;
                tgt_data = '0;
            end
        endcase
    end

endmodule

// ==== mtimer.sv ====
`timescale 1ns/100ps

module mtimer
    import soc_map_pkg::*;
    import bus_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  tgt_cmd_t cmd,
    output tgt_rsp_t rsp,
    output logic     mtip
);
    // register offsets inside the timer window
    localparam logic [ADDR_W-1:0] CMP_OFF  = MTIMECMP_ADDR - TIMER_BASE;
    localparam logic [ADDR_W-1:0] TIME_OFF = MTIME_ADDR - TIMER_BASE;

    logic [DATA_W-1:0] mtime;
    logic [DATA_W-1:0] mtimecmp;

    // mtime free-running, mtimecmp starts at max so mtip stays low
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 1'b1;
            if (cmd.wr && cmd.offset == CMP_OFF) begin
                mtimecmp <= cmd.wdata;
            end
        end
    end

    always_comb begin
        rsp.ack   = cmd.rd || cmd.wr;
        rsp.rdata = '0;
        if (cmd.offset == TIME_OFF) begin
            rsp.rdata = mtime;
        end else if (cmd.offset == CMP_OFF) begin
            rsp.rdata = mtimecmp;
        end
    end

    assign mtip = mtime >= mtimecmp;

endmodule

// ==== plic.sv ====
`timescale 1ns/100ps

module plic
    import soc_map_pkg::*;
    import bus_pkg::*;
#(
    parameter int PLIC_SOURCES = 5
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  tgt_cmd_t              cmd,
    output tgt_rsp_t              rsp,
    input  logic [PLIC_SOURCES:1] irq_src,
    output logic                  meip,
    output logic                  seip
);
    logic [PLIC_SOURCES:1][PRIO_W-1:0] prio;
    logic [PLIC_SOURCES:1]             pending;
    logic [PLIC_SOURCES:1]             irq_q;
    logic [PLIC_SOURCES:1]             clr_mask;
    logic [1:0][PLIC_SOURCES:1]        enable;
    logic [1:0][PRIO_W-1:0]            threshold;
    logic [1:0][ID_W-1:0]              claim_id;
    logic [1:0]                        hit_en;
    logic [1:0]                        hit_th;
    logic [1:0]                        hit_cl;

    // context 0 is M-mode, context 1 is S-mode
    for (genvar ctx = 0; ctx < 2; ctx++) begin : g_ctx
        assign hit_en[ctx] = cmd.offset == PLIC_ENABLE + ctx * PLIC_ENABLE_STRIDE;
        assign hit_th[ctx] = cmd.offset == PLIC_THRESHOLD + ctx * PLIC_CTX_STRIDE;
        assign hit_cl[ctx] = cmd.offset == PLIC_CLAIM + ctx * PLIC_CTX_STRIDE;

        plic_target #(
            .PLIC_SOURCES(PLIC_SOURCES)
        ) u_target (
            .pending    (pending),
            .enable     (enable[ctx]),
            .priorities (prio),
            .threshold  (threshold[ctx]),
            .claim_id   (claim_id[ctx])
        );
    end

    // claim read drops the claimed source
    always_comb begin
        clr_mask = '0;
        for (int ctx = 0; ctx < 2; ctx++) begin
            for (int id = 1; id <= PLIC_SOURCES; id++) begin
                if (cmd.rd && hit_cl[ctx] && claim_id[ctx] == ID_W'(id)) begin
                    clr_mask[id] = 1'b1;
                end
            end
        end
    end

    // register read, bit 0 of pending and enable is id 0
    always_comb begin
        rsp.ack   = cmd.rd || cmd.wr;
        rsp.rdata = '0;
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            if (cmd.offset == ADDR_W'(4 * id)) begin
                rsp.rdata[PRIO_W-1:0] = prio[id];
            end
        end
        if (cmd.offset == PLIC_PENDING) begin
            rsp.rdata[PLIC_SOURCES:0] = {pending, 1'b0};
        end
        for (int ctx = 0; ctx < 2; ctx++) begin
            if (hit_en[ctx]) begin
                rsp.rdata[PLIC_SOURCES:0] = {enable[ctx], 1'b0};
            end
            if (hit_th[ctx]) begin
                rsp.rdata[PRIO_W-1:0] = threshold[ctx];
            end
            if (hit_cl[ctx]) begin
                rsp.rdata[ID_W-1:0] = claim_id[ctx];
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio      <= '0;
            pending   <= '0;
            irq_q     <= '0;
            enable    <= '0;
            threshold <= '0;
            meip      <= 1'b0;
            seip      <= 1'b0;
        end else begin
            // edge gateway, a new edge wins over a claim
            irq_q   <= irq_src;
            pending <= (pending & ~clr_mask) | (irq_src & ~irq_q);
            meip    <= claim_id[0] != '0;
            seip    <= claim_id[1] != '0;
            // claim writes fall through untouched
            if (cmd.wr) begin
                for (int id = 1; id <= PLIC_SOURCES; id++) begin
                    if (cmd.offset == ADDR_W'(4 * id)) begin
                        prio[id] <= cmd.wdata[PRIO_W-1:0];
                    end
                end
                for (int ctx = 0; ctx < 2; ctx++) begin
                    if (hit_en[ctx]) begin
                        enable[ctx] <= cmd.wdata[PLIC_SOURCES:1];
                    end
                    if (hit_th[ctx]) begin
                        threshold[ctx] <= cmd.wdata[PRIO_W-1:0];
                    end
                end
            end
        end
    end

endmodule

// ==== plic_target.sv ====
`timescale 1ns/100ps

module plic_target
    import soc_map_pkg::*;
#(
    parameter int PLIC_SOURCES = 5
) (
    input  logic [PLIC_SOURCES:1]             pending,
    input  logic [PLIC_SOURCES:1]             enable,
    input  logic [PLIC_SOURCES:1][PRIO_W-1:0] priorities,
    input  logic [PRIO_W-1:0]                 threshold,
    output logic [ID_W-1:0]                   claim_id
);
    // running best priority, starts at the threshold
    logic [PRIO_W-1:0] best;

    // strict compare keeps the lowest id on a tie
    always_comb begin
        best     = threshold;
        claim_id = '0;
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            if (pending[id] && enable[id] && priorities[id] > best) begin
                best     = priorities[id];
                claim_id = ID_W'(id);
            end
        end
    end

endmodule

// ==== ram_port.sv ====
`timescale 1ns/100ps

module ram_port
    import bus_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  tgt_cmd_t cmd,
    output tgt_rsp_t rsp
);
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_hi;
    logic [1:0]       lane;
    logic [31:0]      word;
    logic [31:0]      shifted;
    logic             is_d;
    logic             beat2;
    logic             beat2_wr;
    logic [31:0]      lo_q;

    assign idx     = cmd.offset[IDX_W+1:2];
    assign idx_hi  = idx + 1'b1;
    assign lane    = cmd.offset[1:0];
    assign word    = mem[idx];
    // byte lane moved down to bit 0
    assign shifted = word >> {lane, 3'b000};
    assign is_d    = cmd.ls_type[1:0] == 2'b11;

    // second beat of a doubleword follows the strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat2    <= 1'b0;
            beat2_wr <= 1'b0;
        end else begin
            beat2    <= (cmd.rd || cmd.wr) && is_d;
            beat2_wr <= cmd.wr;
        end
    end

    // lane writes, then high word on beat 2
    always_ff @(posedge CLOCK_50) begin
        if (cmd.rd) begin
            lo_q <= word;
        end
        if (cmd.wr) begin
            case (cmd.ls_type[1:0])
                2'b00: mem[idx][{lane, 3'b000} +: 8] <= cmd.wdata[7:0];
                2'b01: mem[idx][{lane[1], 4'b0000} +: 16] <= cmd.wdata[15:0];
                default: mem[idx] <= cmd.wdata[31:0];
            endcase
        end else if (beat2 && beat2_wr) begin
            mem[idx_hi] <= cmd.wdata[63:32];
        end
    end

    // sign or zero extension by load type
    always_comb begin
        rsp.ack = ((cmd.rd || cmd.wr) && !is_d) || beat2;
        case (cmd.ls_type)
            ls_b:    rsp.rdata = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            ls_bu:   rsp.rdata = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            ls_h:    rsp.rdata = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            ls_hu:   rsp.rdata = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            ls_w:    rsp.rdata = {{(DATA_W-32){word[31]}}, word};
            ls_wu:   rsp.rdata = {{(DATA_W-32){1'b0}}, word};
            // low half latched on beat 1
            default: rsp.rdata = {mem[idx_hi], lo_q};
        endcase
    end

endmodule

// ==== soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top
    import soc_map_pkg::*;
    import bus_pkg::*;
#(
    parameter int RAM_WORDS    = 1024,
    parameter int PLIC_SOURCES = 5
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req_valid,
    input  bus_req_t              req,
    input  logic [PLIC_SOURCES:1] irq_src,
    output logic                  done,
    output logic [DATA_W-1:0]     rdata,
    output logic                  meip,
    output logic                  seip,
    output logic                  mtip
);
    region_e           region;
    logic [ADDR_W-1:0] offset;
    logic [ADDR_W-1:0] cur_addr;
    tgt_cmd_t          ram_cmd;
    tgt_cmd_t          plic_cmd;
    tgt_cmd_t          timer_cmd;
    tgt_rsp_t          ram_rsp;
    tgt_rsp_t          plic_rsp;
    tgt_rsp_t          timer_rsp;

    // master side handshake and target strobes
    bus_sequencer u_seq (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req_valid (req_valid),
        .req       (req),
        .region    (region),
        .offset    (offset),
        .ram_cmd   (ram_cmd),
        .plic_cmd  (plic_cmd),
        .timer_cmd (timer_cmd),
        .ram_rsp   (ram_rsp),
        .plic_rsp  (plic_rsp),
        .timer_rsp (timer_rsp),
        .cur_addr  (cur_addr),
        .done      (done),
        .rdata     (rdata)
    );

    addr_decoder #(
        .RAM_WORDS(RAM_WORDS)
    ) u_dec (
        .addr   (cur_addr),
        .region (region),
        .offset (offset)
    );

    ram_port #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cmd      (ram_cmd),
        .rsp      (ram_rsp)
    );

    plic #(
        .PLIC_SOURCES(PLIC_SOURCES)
    ) u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cmd      (plic_cmd),
        .rsp      (plic_rsp),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

    mtimer u_timer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cmd      (timer_cmd),
        .rsp      (timer_rsp),
        .mtip     (mtip)
    );

endmodule

// ==== soc_map_pkg.sv ====
package soc_map_pkg;

    // bus address width
    localparam int ADDR_W = 64;

    // on-chip ram window, RAM_WORDS words of 4 bytes
    localparam logic [ADDR_W-1:0] RAM_BASE = 64'h0000_0000_8000_0000;

    // plic window and register offsets inside it
    localparam logic [ADDR_W-1:0] PLIC_BASE          = 64'h0000_0000_0C00_0000;
    localparam logic [ADDR_W-1:0] PLIC_SIZE          = 64'h0000_0000_0040_0000;
    localparam logic [ADDR_W-1:0] PLIC_PENDING       = 64'h0000_0000_0000_1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE        = 64'h0000_0000_0000_2000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE_STRIDE = 64'h0000_0000_0000_0080;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD     = 64'h0000_0000_0020_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM         = 64'h0000_0000_0020_0004;
    localparam logic [ADDR_W-1:0] PLIC_CTX_STRIDE    = 64'h0000_0000_0000_1000;

    // machine timer window, registers at clint-style addresses
    localparam logic [ADDR_W-1:0] TIMER_BASE    = 64'h0000_0000_0200_0000;
    localparam logic [ADDR_W-1:0] TIMER_SIZE    = 64'h0000_0000_0001_0000;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam logic [ADDR_W-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

    // interrupt priority and source id widths
    localparam int PRIO_W = 3;
    localparam int ID_W   = 5;

    typedef enum logic [1:0] {
        region_none,
        region_ram,
        region_plic,
        region_timer
    } region_e;

endpackage

// ==== tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus
    import soc_map_pkg::*;
    import bus_pkg::*;
();
    localparam int CLK_PERIOD   = 40;
    localparam int RAM_WORDS    = 1024;
    localparam int PLIC_SOURCES = 5;
    localparam int N_DWORDS     = 8;
    localparam int N_BYTES      = N_DWORDS * 8;
    localparam int N_BYTE_WR    = 12;
    localparam int N_HALF_WR    = 8;
    // ram fill + 29 reads per dword, unmapped, plic, timer
    localparam int NUM_TRANS    = N_DWORDS * 30 + N_BYTE_WR + N_HALF_WR
                                  + (N_DWORDS + 4) + 40 + 6;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * 10 + 1000;
    localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 64'h0000_0000_4000_0000;
    localparam logic [ADDR_W-1:0] RAM_END       = RAM_BASE + 4 * RAM_WORDS;

    logic                  CLOCK_50;
    logic                  KEY0;
    logic                  req_valid;
    bus_req_t              req;
    logic [PLIC_SOURCES:1] irq_src;
    logic                  done;
    logic [DATA_W-1:0]     rdata;
    logic                  meip;
    logic                  seip;
    logic                  mtip;

    // reference state
    logic [31:0]           lfsr_state;
    logic [7:0]            ram_model [N_BYTES];
    logic [PLIC_SOURCES:1] pend_model;
    logic [PLIC_SOURCES:1] en_model [2];
    logic [PRIO_W-1:0]     prio_model [1:PLIC_SOURCES];
    logic [PRIO_W-1:0]     thr_model [2];

    soc_bus_top #(
        .RAM_WORDS    (RAM_WORDS),
        .PLIC_SOURCES (PLIC_SOURCES)
    ) dut0 (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req_valid (req_valid),
        .req       (req),
        .irq_src   (irq_src),
        .done      (done),
        .rdata     (rdata),
        .meip      (meip),
        .seip      (seip),
        .mtip      (mtip)
    );

    // 40 ns clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    // galois lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    // little-endian gather from the byte model, then extend
    function automatic logic [63:0] expect_load(input int off, input ls_type_e ls);
        logic [63:0] raw;
        raw = '0;
        for (int i = 0; i < 8; i++) begin
            if (off + i < N_BYTES) begin
                raw[8 * i +: 8] = ram_model[off + i];
            end
        end
        case (ls)
            ls_b:    return {{56{raw[7]}}, raw[7:0]};
            ls_bu:   return {56'd0, raw[7:0]};
            ls_h:    return {{48{raw[15]}}, raw[15:0]};
            ls_hu:   return {48'd0, raw[15:0]};
            ls_w:    return {{32{raw[31]}}, raw[31:0]};
            ls_wu:   return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    // highest qualifying priority wins, lowest id breaks a tie
    function automatic int model_claim(input int ctx);
        logic [PRIO_W-1:0] max_p;
        int                winner;
        max_p  = '0;
        winner = 0;
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            if (pend_model[id] && en_model[ctx][id] && prio_model[id] > thr_model[ctx]
                    && prio_model[id] > max_p) begin
                max_p = prio_model[id];
            end
        end
        for (int id = PLIC_SOURCES; id >= 1; id--) begin
            if (pend_model[id] && en_model[ctx][id] && max_p > thr_model[ctx]
                    && prio_model[id] == max_p) begin
                winner = id;
            end
        end
        return winner;
    endfunction

    task automatic halt_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic value_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        halt_on_error();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        halt_on_error();
    endtask

    // one request, one-cycle req_valid, then wait for done with a bound
    task automatic issue_request(input logic [ADDR_W-1:0] addr, input ls_type_e ls,
                                 input logic write, input logic [DATA_W-1:0] wdata,
                                 output logic [DATA_W-1:0] data);
        bus_req_t r;
        int       cycles;
        int       expected;
        r.addr    = addr;
        r.ls_type = ls;
        r.write   = write;
        r.wdata   = wdata;
        // ram doublewords need a second beat
        expected  = (addr >= RAM_BASE && addr < RAM_END && ls[1:0] == 2'b11) ? 3 : 2;
        @(negedge CLOCK_50);
        assert (done === 1'b1) else value_mismatch("done low before a new request");
        @(posedge CLOCK_50);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge CLOCK_50);
        req_valid <= 1'b0;
        @(negedge CLOCK_50);
        assert (done === 1'b0) else value_mismatch("done did not drop after the request");
        cycles = 0;
        while (done !== 1'b1 && cycles < 4) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        assert (done === 1'b1) else
            abort_run($sformatf("request to address %h never completed, done stayed low",
                                addr));
        assert (cycles == expected) else
            value_mismatch($sformatf("addr %h took %0d cycles, expected %0d",
                                     addr, cycles, expected));
        data = rdata;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input ls_type_e ls,
                             input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] unused;
        issue_request(addr, ls, 1'b1, wdata, unused);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, input ls_type_e ls,
                            output logic [DATA_W-1:0] data);
        issue_request(addr, ls, 1'b0, '0, data);
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr, input ls_type_e ls,
                               input logic [DATA_W-1:0] exp, input string what);
        logic [DATA_W-1:0] got;
        bus_read(addr, ls, got);
        assert (got === exp) else
            value_mismatch($sformatf("%s at %h type %0d: got %h expected %h",
                                     what, addr, ls, got, exp));
    endtask

    task automatic compare_ram_load(input int off, input ls_type_e ls);
        read_expect(RAM_BASE + off, ls, expect_load(off, ls), "ram load");
    endtask

    // interrupt lines are registered, look one edge later
    task automatic check_irq_lines();
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        assert (meip === (model_claim(0) != 0)) else
            value_mismatch($sformatf("meip %b, model claim %0d", meip, model_claim(0)));
        assert (seip === (model_claim(1) != 0)) else
            value_mismatch($sformatf("seip %b, model claim %0d", seip, model_claim(1)));
    endtask

    task automatic plic_write(input logic [ADDR_W-1:0] off, input logic [DATA_W-1:0] data);
        bus_write(PLIC_BASE + off, ls_w, data);
        check_irq_lines();
    endtask

    // rising edge sets pending on the second edge
    task automatic pulse_sources(input logic [PLIC_SOURCES:1] mask);
        @(posedge CLOCK_50);
        irq_src <= mask;
        @(posedge CLOCK_50);
        irq_src <= '0;
        pend_model = pend_model | mask;
        check_irq_lines();
    endtask

    task automatic claim_and_check(input int ctx);
        logic [DATA_W-1:0] got;
        int                expected_id;
        expected_id = model_claim(ctx);
        bus_read(PLIC_BASE + 64'h20_0004 + ctx * 64'h1000, ls_w, got);
        assert (got === DATA_W'(expected_id)) else
            value_mismatch($sformatf("context %0d claim %0d, expected %0d",
                                     ctx, got, expected_id));
        if (expected_id != 0) begin
            pend_model[expected_id] = 1'b0;
        end
        check_irq_lines();
    endtask

    task automatic pending_readback();
        read_expect(PLIC_BASE + 64'h1000, ls_w, DATA_W'({pend_model, 1'b0}), "pending");
    endtask

    task automatic test_ram_sizes();
        logic [63:0] d;
        int          off;
        for (int i = 0; i < N_DWORDS; i++) begin
            d = lfsr_bits(64);
            bus_write(RAM_BASE + 8 * i, ls_d, d);
            for (int b = 0; b < 8; b++) begin
                ram_model[8 * i + b] = d[8 * b +: 8];
            end
        end
        // unsigned codes on stores behave as signed ones
        for (int k = 0; k < N_BYTE_WR; k++) begin
            off = int'(lfsr_bits(6));
            d   = lfsr_bits(8);
            bus_write(RAM_BASE + off, (k % 2) ? ls_bu : ls_b, d);
            ram_model[off] = d[7:0];
        end
        for (int k = 0; k < N_HALF_WR; k++) begin
            off = 2 * int'(lfsr_bits(5));
            d   = lfsr_bits(16);
            bus_write(RAM_BASE + off, (k % 2) ? ls_hu : ls_h, d);
            ram_model[off]     = d[7:0];
            ram_model[off + 1] = d[15:8];
        end
        // every width at every aligned position
        for (int i = 0; i < N_DWORDS; i++) begin
            compare_ram_load(8 * i, ls_d);
            for (int w = 0; w < 2; w++) begin
                compare_ram_load(8 * i + 4 * w, ls_w);
                compare_ram_load(8 * i + 4 * w, ls_wu);
            end
            for (int h = 0; h < 4; h++) begin
                compare_ram_load(8 * i + 2 * h, ls_h);
                compare_ram_load(8 * i + 2 * h, ls_hu);
            end
            for (int b = 0; b < 8; b++) begin
                compare_ram_load(8 * i + b, ls_b);
                compare_ram_load(8 * i + b, ls_bu);
            end
        end
    endtask

    task automatic test_unmapped();
        // first address past the ram window would wrap onto word 0
        bus_write(UNMAPPED_ADDR, ls_d, 64'hDEAD_BEEF_CAFE_F00D);
        bus_write(RAM_END, ls_w, 64'h0000_0000_1234_5678);
        read_expect(UNMAPPED_ADDR, ls_d, '0, "unmapped read");
        read_expect(RAM_END, ls_w, '0, "read past ram");
        for (int i = 0; i < N_DWORDS; i++) begin
            compare_ram_load(8 * i, ls_d);
        end
    endtask

    task automatic test_plic();
        // ids 2 and 3 tie on priority
        prio_model[1] = 3'd2;
        prio_model[2] = 3'd5;
        prio_model[3] = 3'd5;
        prio_model[4] = 3'd1;
        prio_model[5] = 3'd6;
        en_model[0]   = 5'b01111;
        en_model[1]   = 5'b11010;
        thr_model[0]  = 3'd1;
        thr_model[1]  = 3'd2;
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            plic_write(4 * id, DATA_W'(prio_model[id]));
        end
        for (int ctx = 0; ctx < 2; ctx++) begin
            plic_write(64'h2000 + ctx * 64'h80, DATA_W'({en_model[ctx], 1'b0}));
            plic_write(64'h20_0000 + ctx * 64'h1000, DATA_W'(thr_model[ctx]));
        end
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            read_expect(PLIC_BASE + 4 * id, ls_w, DATA_W'(prio_model[id]), "priority");
        end
        for (int ctx = 0; ctx < 2; ctx++) begin
            read_expect(PLIC_BASE + 64'h2000 + ctx * 64'h80, ls_w,
                        DATA_W'({en_model[ctx], 1'b0}), "enable");
            read_expect(PLIC_BASE + 64'h20_0000 + ctx * 64'h1000, ls_w,
                        DATA_W'(thr_model[ctx]), "threshold");
        end
        // ids 1 3 4 5
        pulse_sources(5'b11101);
        pending_readback();
        claim_and_check(0);
        claim_and_check(0);
        claim_and_check(1);
        pending_readback();
        claim_and_check(1);
        // ids 2 3, context 0 sees the tie
        pulse_sources(5'b00110);
        pending_readback();
        claim_and_check(0);
        claim_and_check(1);
        // claim write leaves pending alone
        plic_write(64'h20_0004, 64'd4);
        pending_readback();
        // lower threshold lets id 4 through
        thr_model[0] = 3'd0;
        plic_write(64'h20_0000, 64'd0);
        claim_and_check(0);
        claim_and_check(0);
        pending_readback();
    endtask

    task automatic test_timer();
        logic [DATA_W-1:0] t1;
        logic [DATA_W-1:0] t2;
        logic [DATA_W-1:0] far;
        bus_read(MTIME_ADDR, ls_d, t1);
        bus_read(MTIME_ADDR, ls_d, t2);
        assert (t2 > t1) else
            value_mismatch($sformatf("mtime not increasing, %0d then %0d", t1, t2));
        far = t2 + 64'h0000_0001_0000_0000;
        bus_write(MTIMECMP_ADDR, ls_d, far);
        @(negedge CLOCK_50);
        assert (mtip === 1'b0) else value_mismatch("mtip high with mtimecmp far ahead");
        read_expect(MTIMECMP_ADDR, ls_d, far, "mtimecmp");
        bus_write(MTIMECMP_ADDR, ls_d, 64'd0);
        @(negedge CLOCK_50);
        assert (mtip === 1'b1) else value_mismatch("mtip low with mtimecmp at zero");
        read_expect(MTIMECMP_ADDR, ls_d, 64'd0, "mtimecmp");
    endtask

    // main sequence
    initial begin
        lfsr_state  = 32'd79693;
        KEY0        = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        irq_src     = '0;
        pend_model  = '0;
        en_model[0] = '0;
        en_model[1] = '0;
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        assert (done === 1'b1) else value_mismatch("done not high after reset");
        assert (meip === 1'b0 && seip === 1'b0 && mtip === 1'b0) else
            value_mismatch("interrupt line active after reset");
        test_ram_sizes();
        test_unmapped();
        test_plic();
        test_timer();
        $display("No errors");
        $finish;
    end

    // bound on total run time
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        halt_on_error();
    end

endmodule

// ==== vlog.f ====
soc_map_pkg.sv
bus_pkg.sv
addr_decoder.sv
bus_sequencer.sv
ram_port.sv
plic_target.sv
plic.sv
mtimer.sv
soc_bus_top.sv
tb_soc_bus.sv
